//--- hdl/uart_rx_pkg.sv
package uart_rx_pkg;

    // ========================================
    // widths
    // ========================================

    localparam int DATA_BITS = 8;               // data bits per character

    typedef logic [15:0] baud_div_t;            // clock cycles per bit
    typedef logic [DATA_BITS-1:0] data_t;       // one received character
    typedef logic [2:0] bit_idx_t;              // data bit index in frame

    // ========================================
    // encodings
    // ========================================

    typedef enum logic [1:0]
    {
        PARITY_NONE = 2'd0,
        PARITY_ODD  = 2'd1,
        PARITY_EVEN = 2'd2
    } parity_mode_e;

    // receiver frame FSM
    typedef enum logic [2:0]
    {
        WAIT_IDLE = 3'd0,                       // counting quiet bit times
        IDLE      = 3'd1,                       // armed, waiting for start edge
        START     = 3'd2,
        DATA      = 3'd3,
        PARITY    = 3'd4,
        STOP1     = 3'd5,
        STOP2     = 3'd6,
        DONE      = 3'd7                        // result pulse cycle
    } rx_state_e;

endpackage

//--- hdl/rx_line_filter.sv
`timescale 1ns/1ps

module rx_line_filter
(
    input  logic clk_i,
    input  logic rst,
    input  logic rx_i,
    output logic line_o,
    output logic fall_o
);

    logic sync_q1;
    logic sync_q2;
    logic samp_q;                               // previous synchronised sample
    logic line_q;
    logic line_d_q;                             // line one cycle ago
    logic fall_q;

    // ========================================
    // synchroniser and glitch filter
    // ========================================

    always_ff @(posedge clk_i)
    begin
        if (rst)
        begin
            sync_q1 <= 1'b1;
            sync_q2 <= 1'b1;
            samp_q  <= 1'b1;
            line_q  <= 1'b1;                    // idle line is high
        end
        else
        begin
            sync_q1 <= rx_i;
            sync_q2 <= sync_q1;
            samp_q  <= sync_q2;
            if (sync_q2 == samp_q)
                line_q <= sync_q2;              // two equal samples
        end
    end

    // falling edge of the filtered level
    always_ff @(posedge clk_i)
    begin
        if (rst)
        begin
            line_d_q <= 1'b1;
            fall_q   <= 1'b0;
        end
        else
        begin
            line_d_q <= line_q;
            fall_q   <= line_d_q & ~line_q;
        end
    end

    assign line_o = line_q;
    assign fall_o = fall_q;

endmodule

//--- hdl/rx_bit_timer.sv
`timescale 1ns/1ps

module rx_bit_timer
    import uart_rx_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst,
    input  logic      run_i,
    input  baud_div_t baud_div_i,
    output logic      mid_o,
    output logic      end_o
);

    baud_div_t div_q;                           // divisor held for the frame
    baud_div_t cnt_q;
    baud_div_t half_cnt;
    baud_div_t last_cnt;
    logic      at_last;

    // ========================================
    // divisor capture
    // ========================================

    // follows the input until the timer starts
    always_ff @(posedge clk_i)
    begin
        if (!run_i)
            div_q <= baud_div_i;
    end

    assign half_cnt = div_q >> 1;               // mid-bit sample point
    assign last_cnt = div_q - baud_div_t'(1);
    assign at_last  = (cnt_q == last_cnt);

    // ========================================
    // bit-time counter
    // ========================================

    always_ff @(posedge clk_i)
    begin
        if (rst)
        begin
            cnt_q <= '0;
        end
        else if (!run_i)
        begin
            cnt_q <= '0;                        // restart on every idle cycle
        end
        else if (at_last)
        begin
            cnt_q <= '0;                        // wrap at end of bit
        end
        else
        begin
            cnt_q <= cnt_q + baud_div_t'(1);
        end
    end

    // strobes are quiet while stopped
    assign mid_o = run_i && (cnt_q == half_cnt);
    assign end_o = run_i && at_last;

endmodule

//--- hdl/rx_frame_ctrl.sv
`timescale 1ns/1ps

module rx_frame_ctrl
    import uart_rx_pkg::*;
#(
    parameter int IDLE_BITS = 8
)
(
    input  logic         clk_i,
    input  logic         rst,
    input  logic         rx_en_i,
    input  logic         line_i,
    input  logic         fall_i,
    input  logic         mid_i,
    input  logic         end_i,
    input  parity_mode_e parity_mode_i,
    input  logic         two_stop_i,
    output logic         run_o,
    output data_t        data_o,
    output logic         data_valid_o,
    output logic         parity_err_o,
    output logic         frame_err_o
);

    localparam int IDLE_W = $clog2(IDLE_BITS + 1);
    localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(IDLE_BITS - 1);
    localparam bit_idx_t LAST_BIT = bit_idx_t'(DATA_BITS - 1);

    rx_state_e         state_q;
    rx_state_e         state_d;
    logic [IDLE_W-1:0] idle_cnt_q;
    bit_idx_t          bit_idx_q;
    parity_mode_e      parity_mode_q;
    logic              two_stop_q;
    logic              has_parity;
    data_t             shift_q;
    logic              par_acc_q;               // xor of data bits so far
    logic              par_bad_q;
    logic              finish;
    data_t             data_q;
    logic              data_valid_q;
    logic              parity_err_q;
    logic              frame_err_q;

    assign has_parity = (parity_mode_q != PARITY_NONE);

    // last stop bit judged, or a stop bit read low
    assign finish = rx_en_i && mid_i &&
                    (((state_q == STOP1) && (!line_i || !two_stop_q)) ||
                     (state_q == STOP2));

    // timer runs during a frame, and on a quiet enabled line in WAIT_IDLE
    assign run_o = (state_q == WAIT_IDLE) ? (rx_en_i && line_i) :
                   (state_q inside {START, DATA, PARITY, STOP1, STOP2});

    // ========================================
    // frame FSM
    // ========================================

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            WAIT_IDLE:
                if (end_i && (idle_cnt_q == IDLE_LAST))
                    state_d = IDLE;
            IDLE:
                if (fall_i)
                    state_d = START;
            START:
                if (mid_i && line_i)
                    state_d = IDLE;             // false start, dropped
                else if (end_i)
                    state_d = DATA;
            DATA:
                if (end_i && (bit_idx_q == LAST_BIT))
                    state_d = has_parity ? PARITY : STOP1;
            PARITY:
                if (end_i)
                    state_d = STOP1;
            STOP1:
                if (finish)
                    state_d = DONE;
                else if (end_i)
                    state_d = STOP2;
            STOP2:
                if (finish)
                    state_d = DONE;
            DONE:
                state_d = IDLE;
            default:
                state_d = WAIT_IDLE;
        endcase
        if (!rx_en_i)
            state_d = WAIT_IDLE;                // disable aborts any frame
    end

    always_ff @(posedge clk_i)
    begin
        if (rst)
        begin
            state_q       <= WAIT_IDLE;
            idle_cnt_q    <= '0;
            bit_idx_q     <= '0;
            parity_mode_q <= PARITY_NONE;
            two_stop_q    <= 1'b0;
            par_bad_q     <= 1'b0;
        end
        else
        begin
            state_q <= state_d;

            if ((state_q != WAIT_IDLE) || !run_o)
                idle_cnt_q <= '0;               // low line restarts the count
            else if (end_i)
                idle_cnt_q <= idle_cnt_q + 1'b1;

            if ((state_q == IDLE) && fall_i)
            begin
                parity_mode_q <= parity_mode_i; // format fixed for the frame
                two_stop_q    <= two_stop_i;
                bit_idx_q     <= '0;
                par_bad_q     <= 1'b0;
            end
            else if ((state_q == DATA) && end_i)
            begin
                bit_idx_q <= bit_idx_q + 1'b1;
            end
            else if ((state_q == PARITY) && mid_i)
            begin
                // odd wants an odd count of ones over data and parity bit
                par_bad_q <= (par_acc_q ^ line_i) ^ (parity_mode_q == PARITY_ODD);
            end
        end
    end

    // ========================================
    // data shift and results
    // ========================================

    always_ff @(posedge clk_i)
    begin
        if ((state_q == IDLE) && fall_i)
        begin
            par_acc_q <= 1'b0;
        end
        else if ((state_q == DATA) && mid_i)
        begin
            shift_q   <= {line_i, shift_q[DATA_BITS-1:1]};  // lsb first
            par_acc_q <= par_acc_q ^ line_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst)
        begin
            data_q       <= '0;
            data_valid_q <= 1'b0;
            parity_err_q <= 1'b0;
            frame_err_q  <= 1'b0;
        end
        else
        begin
            data_valid_q <= finish && line_i && !par_bad_q;
            parity_err_q <= finish && par_bad_q;
            frame_err_q  <= finish && !line_i;
            if (finish && line_i && !par_bad_q)
                data_q <= shift_q;              // good frame only
        end
    end

    assign data_o       = data_q;
    assign data_valid_o = data_valid_q;
    assign parity_err_o = parity_err_q;
    assign frame_err_o  = frame_err_q;

endmodule

//--- hdl/uart_rx_top.sv
`timescale 1ns/1ps

module uart_rx_top
    import uart_rx_pkg::*;
#(
    parameter int IDLE_BITS = 8
)
(
    input  logic         clk_i,
    input  logic         rst,
    input  logic         rx_i,
    input  logic         rx_en_i,
    input  baud_div_t    baud_div_i,
    input  parity_mode_e parity_mode_i,
    input  logic         two_stop_i,
    output data_t        data_o,
    output logic         data_valid_o,
    output logic         parity_err_o,
    output logic         frame_err_o
);

    logic line;                                 // filtered rx level
    logic fall;
    logic run;
    logic bit_mid;
    logic bit_end;

    rx_line_filter rx_line_filter_i
    (
        .clk_i  (clk_i),
        .rst    (rst),
        .rx_i   (rx_i),
        .line_o (line),
        .fall_o (fall)
    );

    rx_bit_timer rx_bit_timer_i
    (
        .clk_i      (clk_i),
        .rst        (rst),
        .run_i      (run),
        .baud_div_i (baud_div_i),
        .mid_o      (bit_mid),
        .end_o      (bit_end)
    );

    rx_frame_ctrl #(
        .IDLE_BITS (IDLE_BITS)
    ) rx_frame_ctrl_i
    (
        .clk_i         (clk_i),
        .rst           (rst),
        .rx_en_i       (rx_en_i),
        .line_i        (line),
        .fall_i        (fall),
        .mid_i         (bit_mid),
        .end_i         (bit_end),
        .parity_mode_i (parity_mode_i),
        .two_stop_i    (two_stop_i),
        .run_o         (run),
        .data_o        (data_o),
        .data_valid_o  (data_valid_o),
        .parity_err_o  (parity_err_o),
        .frame_err_o   (frame_err_o)
    );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
#(
    parameter int PERIOD_NS = 8
)
(
    output logic clk_o
);

    initial
    begin
        clk_o = 1'b0;
        forever
            #(PERIOD_NS / 2) clk_o = ~clk_o;    // half period per phase
    end

endmodule

//--- dv/uart_rx_assertions.sv
`timescale 1ns/1ps

module uart_rx_assertions
    import uart_rx_pkg::*;
(
    input logic  clk_i,
    input logic  rst,
    input logic  rx_en_i,
    input data_t data_i,
    input logic  data_valid_i,
    input logic  parity_err_i,
    input logic  frame_err_i
);

    logic any_err;

    assign any_err = parity_err_i || frame_err_i;

    // ========================================
    // result pulses
    // ========================================

    a_valid_one_cycle: assert property (@(posedge clk_i) disable iff (rst)
        data_valid_i |=> !data_valid_i)
        else $error("data_valid_o high for more than one cycle");

    a_perr_one_cycle: assert property (@(posedge clk_i) disable iff (rst)
        parity_err_i |=> !parity_err_i)
        else $error("parity_err_o high for more than one cycle");

    a_ferr_one_cycle: assert property (@(posedge clk_i) disable iff (rst)
        frame_err_i |=> !frame_err_i)
        else $error("frame_err_o high for more than one cycle");

    a_valid_no_err: assert property (@(posedge clk_i) disable iff (rst)
        !(data_valid_i && any_err))
        else $error("data_valid_o together with an error pulse");

    a_quiet_disabled: assert property (@(posedge clk_i) disable iff (rst)
        !rx_en_i |-> !(data_valid_i || any_err))
        else $error("result pulse while rx_en_i is low");

    // held character only moves on a good frame
    a_data_hold: assert property (@(posedge clk_i) disable iff (rst)
        !$stable(data_i) |-> data_valid_i)
        else $error("data_o changed without data_valid_o");

endmodule

//--- dv/uart_rx_tb.sv
`timescale 1ns/1ps

module uart_rx_tb
    import uart_rx_pkg::*;
();

    localparam int IDLE_BITS   = 8;
    localparam int MIN_DIV     = 8;
    localparam int MAX_DIV     = 40;
    localparam int N_RANDOM    = 24;
    localparam int N_PARITY    = 16;
    localparam int N_EVENTS    = N_RANDOM + N_PARITY + 16;
    // each event is at most a quiet wait, a gap, a frame and the result window
    localparam int CYCLE_LIMIT = 100 + (IDLE_BITS + 1) * 16 +
                                 N_EVENTS * (IDLE_BITS + 18) * MAX_DIV;

    logic         clk;
    logic         rst;
    logic         rx;
    logic         rx_en;
    baud_div_t    baud_div;
    parity_mode_e parity_mode;
    logic         two_stop;
    data_t        data;
    logic         data_valid;
    logic         parity_err;
    logic         frame_err;

    int    seed;
    int    div;
    int    cycles = 0;
    int    frames = 0;
    int    value_errs = 0;
    int    missing_errs = 0;
    int    n_valid;
    int    n_perr;
    int    n_ferr;
    data_t exp_data;                            // character data_o should hold

    tb_clk_gen #(.PERIOD_NS(8)) tb_clk_gen_i (.clk_o(clk));

    uart_rx_top #(
        .IDLE_BITS (IDLE_BITS)
    ) uart_rx_top_i
    (
        .clk_i         (clk),
        .rst           (rst),
        .rx_i          (rx),
        .rx_en_i       (rx_en),
        .baud_div_i    (baud_div),
        .parity_mode_i (parity_mode),
        .two_stop_i    (two_stop),
        .data_o        (data),
        .data_valid_o  (data_valid),
        .parity_err_o  (parity_err),
        .frame_err_o   (frame_err)
    );

    bind uart_rx_top uart_rx_assertions uart_rx_assertions_i
    (
        .clk_i        (clk_i),
        .rst          (rst),
        .rx_en_i      (rx_en_i),
        .data_i       (data_o),
        .data_valid_i (data_valid_o),
        .parity_err_i (parity_err_o),
        .frame_err_i  (frame_err_o)
    );

    // ========================================
    // pulse counter and watchdog
    // ========================================

    always @(posedge clk)
    begin
        if (!rst)
        begin
            n_valid = n_valid + int'(data_valid);
            n_perr  = n_perr + int'(parity_err);
            n_ferr  = n_ferr + int'(frame_err);
        end
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic clear_counts();
        n_valid = 0;
        n_perr  = 0;
        n_ferr  = 0;
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp)
        begin
            value_errs++;
            $display("ERR %0t %s got 0x%0h exp 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_counts(input int ev, input int ep, input int ef);
        check_value("data_valid_o", n_valid, ev);
        check_value("parity_err_o", n_perr, ep);
        check_value("frame_err_o", n_ferr, ef);
    endtask

    task automatic drive_bit(input logic b, input int div_c);
        rx = b;
        wait_cycles(div_c);
    endtask

    // low_stop 1 or 2 pulls that stop bit low
    task automatic send_frame(input data_t d, input int div_c, input parity_mode_e pm,
                              input logic two, input logic flip_par, input int low_stop);
        logic par;
        par = (^d) ^ (pm == PARITY_ODD);        // odd mode wants an odd total
        drive_bit(1'b0, div_c);
        for (int i = 0; i < DATA_BITS; i++)
            drive_bit(d[i], div_c);
        if (pm != PARITY_NONE)
            drive_bit(par ^ flip_par, div_c);
        drive_bit(low_stop != 1, div_c);
        if (two)
            drive_bit(low_stop != 2, div_c);
        rx = 1'b1;
    endtask

    task automatic run_frame(input data_t d, input int div_c, input parity_mode_e pm,
                             input logic two, input logic flip_par, input int low_stop,
                             input logic expect_rx);
        int exp_perr;
        int exp_ferr;
        int exp_valid;
        int waited;
        exp_perr  = (expect_rx && flip_par && pm != PARITY_NONE) ? 1 : 0;
        exp_ferr  = (expect_rx && (low_stop == 1 || (low_stop == 2 && two))) ? 1 : 0;
        exp_valid = (expect_rx && exp_perr == 0 && exp_ferr == 0) ? 1 : 0;
        if (exp_valid == 1)
            exp_data = d;
        baud_div    = baud_div_t'(div_c);
        parity_mode = pm;
        two_stop    = two;
        clear_counts();
        wait_cycles(2 * div_c);                 // idle gap
        send_frame(d, div_c, pm, two, flip_par, low_stop);
        waited = 0;
        while ((n_valid + n_perr + n_ferr) == 0 && waited < 3 * div_c)
        begin
            wait_cycles(1);
            waited++;
        end
        if (expect_rx && (n_valid + n_perr + n_ferr) == 0)
        begin
            missing_errs++;
            $display("%0t no result within three bit times for byte 0x%02h", $time, d);
        end
        wait_cycles(2);
        check_counts(exp_valid, exp_perr, exp_ferr);
        check_value("data_o", int'(data), int'(exp_data));
        frames++;
    endtask

    task automatic low_pulse(input int width, input int div_c);
        clear_counts();
        wait_cycles(2 * div_c);
        rx = 1'b0;
        wait_cycles(width);
        rx = 1'b1;
        wait_cycles((DATA_BITS + 5) * div_c);  // a wrongly taken start ends by now
        check_counts(0, 0, 0);
    endtask

    // ========================================
    // test sequence
    // ========================================

    initial
    begin
        seed        = 31;
        rst         = 1'b1;
        rx          = 1'b1;
        rx_en       = 1'b0;                     // timer latches the divisor first
        baud_div    = baud_div_t'(16);
        parity_mode = PARITY_NONE;
        two_stop    = 1'b0;
        exp_data    = '0;
        clear_counts();
        wait_cycles(10);
        rst = 1'b0;
        check_value("data_o", int'(data), 0);
        check_value("data_valid_o", int'(data_valid), 0);
        check_value("parity_err_o", int'(parity_err), 0);
        check_value("frame_err_o", int'(frame_err), 0);
        wait_cycles(2);
        rx_en = 1'b1;
        wait_cycles((IDLE_BITS + 1) * 16);

        for (int i = 0; i < N_RANDOM; i++)
            run_frame(data_t'(rand_range(0, 255)), rand_range(MIN_DIV, MAX_DIV),
                      PARITY_NONE, rand_range(0, 1) == 1, 1'b0, 0, 1'b1);
        for (int i = 0; i < N_PARITY; i++)
            run_frame(data_t'(rand_range(0, 255)), rand_range(MIN_DIV, MAX_DIV),
                      (i % 2 == 0) ? PARITY_ODD : PARITY_EVEN,
                      rand_range(0, 1) == 1, 1'b0, 0, 1'b1);

        // bad parity, then stop bits pulled low
        run_frame(data_t'(rand_range(0, 255)), 16, PARITY_ODD, 1'b0, 1'b1, 0, 1'b1);
        run_frame(data_t'(rand_range(0, 255)), 24, PARITY_EVEN, 1'b1, 1'b1, 0, 1'b1);
        run_frame(data_t'(rand_range(0, 255)), 12, PARITY_NONE, 1'b0, 1'b0, 1, 1'b1);
        run_frame(data_t'(rand_range(0, 255)), 20, PARITY_NONE, 1'b1, 1'b0, 1, 1'b1);
        run_frame(data_t'(rand_range(0, 255)), 9, PARITY_EVEN, 1'b1, 1'b0, 2, 1'b1);

        // glitch, short low pulse, frame while disabled
        div = rand_range(MIN_DIV, MAX_DIV);
        run_frame(data_t'(rand_range(0, 255)), div, PARITY_NONE, 1'b0, 1'b0, 0, 1'b1);
        low_pulse(1, div);
        run_frame(data_t'(rand_range(0, 255)), div, PARITY_NONE, 1'b0, 1'b0, 0, 1'b1);
        low_pulse(div / 2 - 2, div);
        run_frame(data_t'(rand_range(0, 255)), div, PARITY_NONE, 1'b0, 1'b0, 0, 1'b1);
        rx_en = 1'b0;
        run_frame(data_t'(rand_range(0, 255)), div, PARITY_NONE, 1'b0, 1'b0, 0, 1'b0);
        rx_en = 1'b1;
        wait_cycles((IDLE_BITS + 1) * div);
        run_frame(data_t'(rand_range(0, 255)), div, PARITY_NONE, 1'b1, 1'b0, 0, 1'b1);

        // frame too soon after enable is dropped
        rx_en = 1'b0;
        wait_cycles(4);
        rx_en = 1'b1;
        run_frame(8'h55, div, PARITY_NONE, 1'b0, 1'b0, 0, 1'b0);
        wait_cycles((IDLE_BITS + 1) * div);
        run_frame(data_t'(rand_range(0, 255)), div, PARITY_NONE, 1'b0, 1'b0, 0, 1'b1);

        $display("done: %0d frames, %0d value errors, %0d missing results",
                 frames, value_errs, missing_errs);
        if (value_errs + missing_errs == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- build.f
hdl/uart_rx_pkg.sv
hdl/rx_line_filter.sv
hdl/rx_bit_timer.sv
hdl/rx_frame_ctrl.sv
hdl/uart_rx_top.sv
dv/tb_clk_gen.sv
dv/uart_rx_assertions.sv
dv/uart_rx_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = uart_rx_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
